//--- list.f
+incdir+tb
source/telemetry_pkg.sv
source/usb_state_encoder.sv
source/sof_divider.sv
source/telemetry_capture.sv
source/telemetry_fifo.sv
source/byte_serializer.sv
source/bulk_telemetry.sv
tb/bulk_telemetry_tb.sv

//--- source/bulk_telemetry.sv
`timescale 1ns/1ps
module bulk_telemetry (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 timeout_i,
  input  logic                                 usb_sent_i,
  input  logic                                 usb_recv_i,
  input  logic                                 tok_recv_i,
  input  logic [2:0]                           usb_error_i,
  input  logic [3:0]                           usb_state_i,
  input  logic [7:0]                           blk_state_i,
  input  logic [1:0]                           line_state_i,
  input  logic                                 usb_reset_i,
  input  logic                                 crc_error_i,
  input  logic [3:0]                           usb_endpt_i,
  input  logic [3:0]                           usb_tuser_i,
  input  logic [3:0]                           ctl_state_i,
  input  logic [3:0]                           phy_state_i,
  input  logic                                 usb_sof_i,
  input  logic                                 high_speed_i,
  input  logic                                 usb_enum_i,
  input  logic                                 start_i,
  input  logic                                 select_i,
  input  logic [3:0]                           endpt_i,
  input  logic                                 m_ready_i,
  output logic [telemetry_pkg::level_bits-1:0] level_o,
  output logic                                 m_valid_o,
  output logic                                 m_last_o,
  output logic [7:0]                           m_data_o
);
  import telemetry_pkg::*;

  err_code_t       enc_err_code;
  blk_index_t      enc_blk_index;
  logic [1:0]      enc_line_state;
  logic            enc_usb_reset;
  logic            enc_crc_error;
  logic [3:0]      enc_usb_endpt;
  logic [3:0]      enc_usb_tuser;
  logic [3:0]      enc_usb_state;
  logic [3:0]      enc_ctl_state;
  logic [3:0]      enc_phy_state;
  logic            sof_tick;
  logic            wr_valid;
  logic            wr_ready;
  logic            wr_last;
  telemetry_word_u wr_word;
  logic            rd_valid;
  logic            rd_ready;
  logic            rd_last;
  telemetry_word_u rd_word;

  usb_state_encoder encoder_inst (
    .clock        (clock),
    .reset        (reset),
    .timeout_i    (timeout_i),
    .usb_sent_i   (usb_sent_i),
    .usb_recv_i   (usb_recv_i),
    .tok_recv_i   (tok_recv_i),
    .usb_error_i  (usb_error_i),
    .usb_state_i  (usb_state_i),
    .blk_state_i  (blk_state_i),
    .line_state_i (line_state_i),
    .usb_reset_i  (usb_reset_i),
    .crc_error_i  (crc_error_i),
    .usb_endpt_i  (usb_endpt_i),
    .usb_tuser_i  (usb_tuser_i),
    .ctl_state_i  (ctl_state_i),
    .phy_state_i  (phy_state_i),
    .err_code_o   (enc_err_code),
    .blk_index_o  (enc_blk_index),
    .line_state_o (enc_line_state),
    .usb_reset_o  (enc_usb_reset),
    .crc_error_o  (enc_crc_error),
    .usb_endpt_o  (enc_usb_endpt),
    .usb_tuser_o  (enc_usb_tuser),
    .usb_state_o  (enc_usb_state),
    .ctl_state_o  (enc_ctl_state),
    .phy_state_o  (enc_phy_state)
  );

  sof_divider sof_inst (
    .clock        (clock),
    .reset        (reset),
    .usb_sof_i    (usb_sof_i),
    .high_speed_i (high_speed_i),
    .sof_tick_o   (sof_tick)
  );

  telemetry_capture capture_inst (
    .clock        (clock),
    .reset        (reset),
    .usb_enum_i   (usb_enum_i),
    .err_code_i   (enc_err_code),
    .blk_index_i  (enc_blk_index),
    .line_state_i (enc_line_state),
    .usb_reset_i  (enc_usb_reset),
    .crc_error_i  (enc_crc_error),
    .usb_endpt_i  (enc_usb_endpt),
    .usb_tuser_i  (enc_usb_tuser),
    .usb_state_i  (enc_usb_state),
    .ctl_state_i  (enc_ctl_state),
    .phy_state_i  (enc_phy_state),
    .sof_tick_i   (sof_tick),
    .wr_ready_i   (wr_ready),
    .wr_valid_o   (wr_valid),
    .wr_word_o    (wr_word),
    .wr_last_o    (wr_last)
  );

  telemetry_fifo fifo_inst (
    .clock      (clock),
    .reset      (reset),
    .wr_valid_i (wr_valid),
    .wr_word_i  (wr_word),
    .wr_last_i  (wr_last),
    .rd_ready_i (rd_ready),
    .wr_ready_o (wr_ready),
    .rd_valid_o (rd_valid),
    .rd_word_o  (rd_word),
    .rd_last_o  (rd_last),
    .level_o    (level_o)
  );

  byte_serializer serializer_inst (
    .clock      (clock),
    .reset      (reset),
    .usb_enum_i (usb_enum_i),
    .start_i    (start_i),
    .select_i   (select_i),
    .endpt_i    (endpt_i),
    .rd_valid_i (rd_valid),
    .rd_word_i  (rd_word),
    .rd_last_i  (rd_last),
    .m_ready_i  (m_ready_i),
    .rd_ready_o (rd_ready),
    .m_valid_o  (m_valid_o),
    .m_last_o   (m_last_o),
    .m_data_o   (m_data_o)
  );

endmodule

//--- source/byte_serializer.sv
`timescale 1ns/1ps
module byte_serializer (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          usb_enum_i,
  input  logic                          start_i,
  input  logic                          select_i,
  input  logic [3:0]                    endpt_i,
  input  logic                          rd_valid_i,
  input  telemetry_pkg::telemetry_word_u rd_word_i,
  input  logic                          rd_last_i,
  input  logic                          m_ready_i,
  output logic                          rd_ready_o,
  output logic                          m_valid_o,
  output logic                          m_last_o,
  output logic [7:0]                    m_data_o
);
  import telemetry_pkg::*;

  logic            sel_q;
  logic            busy_q;
  logic            last_q;
  logic [1:0]      byte_q;
  telemetry_word_u word_q;
  logic            select_hit;
  logic            rd_fire;
  logic            byte_fire;

  assign select_hit = usb_enum_i && start_i && select_i && (endpt_i == telemetry_endpoint);

  // Take a new word only once the held one is fully sent
  assign rd_ready_o = sel_q && !busy_q;
  assign rd_fire = rd_valid_i && rd_ready_o;

  assign m_valid_o = busy_q;
  assign m_data_o = word_q.bytes[0];
  assign m_last_o = busy_q && last_q && (byte_q == 2'd3);
  assign byte_fire = m_valid_o && m_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q <= 1'b0;
    end else if (select_hit) begin
      sel_q <= 1'b1;
    end else if (byte_fire && m_last_o) begin
      sel_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy_q <= 1'b0;
      byte_q <= '0;
    end else if (rd_fire) begin
      busy_q <= 1'b1;
      byte_q <= '0;
    end else if (byte_fire) begin
      byte_q <= byte_q + 1'b1;
      if (byte_q == 2'd3) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Low byte first, next byte shifts down on each accept
  always_ff @(posedge clock) begin
    if (rd_fire) begin
      word_q <= rd_word_i;
      last_q <= rd_last_i;
    end else if (byte_fire) begin
      word_q.bytes <= {8'h00, word_q.bytes[3:1]};
    end
  end

  stall_hold_a: assert property (@(posedge clock) disable iff (reset)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o) && $stable(m_last_o));

endmodule

//--- source/sof_divider.sv
`timescale 1ns/1ps
module sof_divider (
  input  logic clock,
  input  logic reset,
  input  logic usb_sof_i,
  input  logic high_speed_i,
  output logic sof_tick_o
);
  import telemetry_pkg::*;

  logic                      sof_q;
  logic                      sof_rise;
  logic [sof_count_bits-1:0] count_q;
  logic [sof_count_bits:0]   step;
  logic [sof_count_bits:0]   count_next;

  // High speed sends eight SOFs per millisecond, full speed one
  assign step = high_speed_i ? (sof_count_bits + 1)'(1) : (sof_count_bits + 1)'(8);
  assign count_next = {1'b0, count_q} + step;
  assign sof_rise = usb_sof_i && !sof_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      sof_q      <= 1'b0;
      count_q    <= '0;
      sof_tick_o <= 1'b0;
    end else begin
      sof_q <= usb_sof_i;
      if (sof_rise) begin
        count_q <= count_next[sof_count_bits-1:0];
      end
      // Carry out of the accumulator marks 256 ms
      sof_tick_o <= sof_rise && count_next[sof_count_bits];
    end
  end

  single_tick_a: assert property (@(posedge clock) disable iff (reset)
    sof_tick_o |=> !sof_tick_o);

endmodule

//--- source/telemetry_capture.sv
`timescale 1ns/1ps
module telemetry_capture (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          usb_enum_i,
  input  telemetry_pkg::err_code_t       err_code_i,
  input  telemetry_pkg::blk_index_t      blk_index_i,
  input  logic [1:0]                    line_state_i,
  input  logic                          usb_reset_i,
  input  logic                          crc_error_i,
  input  logic [3:0]                    usb_endpt_i,
  input  logic [3:0]                    usb_tuser_i,
  input  logic [3:0]                    usb_state_i,
  input  logic [3:0]                    ctl_state_i,
  input  logic [3:0]                    phy_state_i,
  input  logic                          sof_tick_i,
  input  logic                          wr_ready_i,
  output logic                          wr_valid_o,
  output telemetry_pkg::telemetry_word_u wr_word_o,
  output logic                          wr_last_o
);
  import telemetry_pkg::*;

  localparam int count_bits = $clog2(packet_words);

  logic [28:0]           prev_q;
  logic [count_bits-1:0] count_q;
  logic                  wr_fire;

  always_comb begin
    wr_word_o.fields.zero       = 1'b0;
    wr_word_o.fields.line_state = line_state_i;
    wr_word_o.fields.usb_reset  = usb_reset_i;
    wr_word_o.fields.usb_endpt  = usb_endpt_i;
    wr_word_o.fields.usb_tuser  = usb_tuser_i;
    wr_word_o.fields.usb_state  = usb_state_i;
    wr_word_o.fields.crc_error  = crc_error_i;
    wr_word_o.fields.err_code   = err_code_i;
    wr_word_o.fields.sof_tick   = sof_tick_i;
    wr_word_o.fields.blk_index  = blk_index_i;
    wr_word_o.fields.ctl_state  = ctl_state_i;
    wr_word_o.fields.phy_state  = phy_state_i;
  end

  // Line state toggles too often to be worth a word
  assign wr_valid_o = usb_enum_i && (wr_word_o[28:0] != prev_q);
  assign wr_fire = wr_valid_o && wr_ready_i;
  assign wr_last_o = count_q == count_bits'(packet_words - 1);

  // Compare against last cycle's word, written or dropped
  always_ff @(posedge clock) begin
    if (reset) begin
      prev_q <= '0;
    end else begin
      prev_q <= wr_word_o[28:0];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
    end else if (wr_fire) begin
      if (wr_last_o) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

//--- source/telemetry_fifo.sv
`timescale 1ns/1ps
module telemetry_fifo (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 wr_valid_i,
  input  telemetry_pkg::telemetry_word_u        wr_word_i,
  input  logic                                 wr_last_i,
  input  logic                                 rd_ready_i,
  output logic                                 wr_ready_o,
  output logic                                 rd_valid_o,
  output telemetry_pkg::telemetry_word_u        rd_word_o,
  output logic                                 rd_last_o,
  output logic [telemetry_pkg::level_bits-1:0] level_o
);
  import telemetry_pkg::*;

  localparam int addr_bits = $clog2(fifo_depth);

  logic [32:0]          mem [fifo_depth];
  logic [addr_bits-1:0] wr_ptr_q;
  logic [addr_bits-1:0] rd_ptr_q;
  logic                 wr_fire;
  logic                 rd_fire;
  logic                 mem_empty;
  logic                 load;
  logic                 mem_wr;
  logic                 mem_rd;

  assign wr_ready_o = level_o != level_bits'(fifo_depth);
  assign wr_fire = wr_valid_i && wr_ready_o;
  assign rd_fire = rd_valid_o && rd_ready_i;
  assign mem_empty = wr_ptr_q == rd_ptr_q;
  // Output register can take a new word
  assign load = !rd_valid_o || rd_ready_i;
  assign mem_rd = load && !mem_empty;
  // Into an empty FIFO the word bypasses the memory
  assign mem_wr = wr_fire && !(load && mem_empty);

  always_ff @(posedge clock) begin
    if (mem_wr) begin
      mem[wr_ptr_q] <= {wr_last_i, wr_word_i};
    end
  end

  always_ff @(posedge clock) begin
    if (mem_rd) begin
      rd_word_o <= mem[rd_ptr_q][31:0];
      rd_last_o <= mem[rd_ptr_q][32];
    end else if (load && wr_fire) begin
      rd_word_o <= wr_word_i;
      rd_last_o <= wr_last_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      rd_valid_o <= 1'b0;
      level_o    <= '0;
    end else begin
      if (mem_wr) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (load) begin
        rd_valid_o <= !mem_empty || wr_fire;
      end
      case ({wr_fire, rd_fire})
        2'b10:   level_o <= level_o + 1'b1;
        2'b01:   level_o <= level_o - 1'b1;
        default: level_o <= level_o;
      endcase
    end
  end

  no_overwrite_a: assert property (@(posedge clock) disable iff (reset)
    mem_wr |-> (wr_ptr_q + 1'b1) != rd_ptr_q);

  no_empty_read_a: assert property (@(posedge clock) disable iff (reset)
    rd_fire |-> level_o != '0);

endmodule

//--- source/telemetry_pkg.sv
package telemetry_pkg;

  localparam logic [3:0] telemetry_endpoint = 4'd2;
  localparam int packet_words = 8;
  localparam int fifo_depth = 512;
  localparam int level_bits = 10;
  localparam int sof_count_bits = 11;

  typedef logic [2:0] err_code_t;
  typedef logic [2:0] blk_index_t;

  // Error sources, highest priority first
  localparam err_code_t err_timeout = 3'd7;
  localparam err_code_t err_suspend = 3'd6;
  localparam err_code_t err_sent = 3'd5;
  localparam err_code_t err_recv = 3'd4;
  localparam err_code_t err_token = 3'd3;

  localparam logic [3:0] usb_state_suspend = 4'h8;
  localparam blk_index_t blk_index_invalid = 3'd7;
  localparam logic [1:0] line_state_j = 2'b01;

  typedef union packed {
    struct packed {
      logic       zero;
      logic [1:0] line_state;
      logic       usb_reset;
      logic [3:0] usb_endpt;
      logic [3:0] usb_tuser;
      logic [3:0] usb_state;
      logic       crc_error;
      err_code_t  err_code;
      logic       sof_tick;
      blk_index_t blk_index;
      logic [3:0] ctl_state;
      logic [3:0] phy_state;
    } fields;
    // Byte 0 is the low byte and goes out first
    logic [3:0][7:0] bytes;
  } telemetry_word_u;

endpackage

//--- source/usb_state_encoder.sv
`timescale 1ns/1ps
module usb_state_encoder (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     timeout_i,
  input  logic                     usb_sent_i,
  input  logic                     usb_recv_i,
  input  logic                     tok_recv_i,
  input  logic [2:0]               usb_error_i,
  input  logic [3:0]               usb_state_i,
  input  logic [7:0]               blk_state_i,
  input  logic [1:0]               line_state_i,
  input  logic                     usb_reset_i,
  input  logic                     crc_error_i,
  input  logic [3:0]               usb_endpt_i,
  input  logic [3:0]               usb_tuser_i,
  input  logic [3:0]               ctl_state_i,
  input  logic [3:0]               phy_state_i,
  output telemetry_pkg::err_code_t  err_code_o,
  output telemetry_pkg::blk_index_t blk_index_o,
  output logic [1:0]               line_state_o,
  output logic                     usb_reset_o,
  output logic                     crc_error_o,
  output logic [3:0]               usb_endpt_o,
  output logic [3:0]               usb_tuser_o,
  output logic [3:0]               usb_state_o,
  output logic [3:0]               ctl_state_o,
  output logic [3:0]               phy_state_o
);
  import telemetry_pkg::*;

  err_code_t  err_code;
  blk_index_t blk_index;

  // Strobes override the core's own error field
  always_comb begin
    if (timeout_i) begin
      err_code = err_timeout;
    end else if (usb_state_i == usb_state_suspend) begin
      err_code = err_suspend;
    end else if (usb_sent_i) begin
      err_code = err_sent;
    end else if (usb_recv_i) begin
      err_code = err_recv;
    end else if (tok_recv_i) begin
      err_code = err_token;
    end else begin
      err_code = usb_error_i;
    end
  end

  always_comb begin
    case (blk_state_i)
      8'h01:   blk_index = 3'd0;
      8'h02:   blk_index = 3'd1;
      8'h04:   blk_index = 3'd2;
      8'h08:   blk_index = 3'd3;
      8'h10:   blk_index = 3'd4;
      8'h20:   blk_index = 3'd5;
      8'h40:   blk_index = 3'd6;
      default: blk_index = blk_index_invalid;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      err_code_o   <= '0;
      blk_index_o  <= '0;
      line_state_o <= line_state_j;
      usb_reset_o  <= 1'b0;
      crc_error_o  <= 1'b0;
      usb_endpt_o  <= '0;
      usb_tuser_o  <= '0;
      usb_state_o  <= '0;
      ctl_state_o  <= '0;
      phy_state_o  <= '0;
    end else begin
      err_code_o   <= err_code;
      blk_index_o  <= blk_index;
      line_state_o <= line_state_i;
      usb_reset_o  <= usb_reset_i;
      crc_error_o  <= crc_error_i;
      usb_endpt_o  <= usb_endpt_i;
      usb_tuser_o  <= usb_tuser_i;
      usb_state_o  <= usb_state_i;
      ctl_state_o  <= ctl_state_i;
      phy_state_o  <= phy_state_i;
    end
  end

  timeout_code_a: assert property (@(posedge clock) disable iff (reset)
    timeout_i |=> err_code_o == err_timeout);

endmodule

//--- tb/telemetry_model.svh
`ifndef TELEMETRY_MODEL_SVH
`define TELEMETRY_MODEL_SVH

// Timeout first, then suspend, then the sent, recv and token strobes and the core's own error
function automatic logic [2:0] priority_err_code(
  input logic       timeout,
  input logic       sent,
  input logic       recv,
  input logic       token,
  input logic [3:0] usb_state,
  input logic [2:0] usb_error
);
  return timeout ? 3'd7 :
         (usb_state == 4'h8) ? 3'd6 :
         sent ? 3'd5 :
         recv ? 3'd4 :
         token ? 3'd3 : usb_error;
endfunction

// One-hot bit 0 to 6 gives its position and anything else reads 7
function automatic logic [2:0] one_hot_index(input logic [7:0] blk_state);
  logic [2:0] index;
  index = 3'd7;
  for (int i = 0; i < 7; i++) begin
    if (blk_state == (8'h01 << i)) begin
      index = 3'(i);
    end
  end
  return index;
endfunction

function automatic logic [31:0] pack_word(
  input logic [1:0] line_state,
  input logic       usb_reset,
  input logic [3:0] usb_endpt,
  input logic [3:0] usb_tuser,
  input logic [3:0] usb_state,
  input logic       crc_error,
  input logic [2:0] err_code,
  input logic       sof_tick,
  input logic [2:0] blk_index,
  input logic [3:0] ctl_state,
  input logic [3:0] phy_state
);
  return {1'b0, line_state, usb_reset, usb_endpt, usb_tuser, usb_state,
          crc_error, err_code, sof_tick, blk_index, ctl_state, phy_state};
endfunction

// Bit 11 of the sum is the carry that marks 256 ms
function automatic logic [11:0] accumulate_sof(input logic [10:0] acc, input logic high_speed);
  return {1'b0, acc} + (high_speed ? 12'd1 : 12'd8);
endfunction

`endif

//--- tb/bulk_telemetry_tb.sv
`timescale 1ns/1ps
module bulk_telemetry_tb;
  import telemetry_pkg::*;

  // The 2048 high-speed SOFs dominate the length of all phases
  localparam int test_cycles = 5200;
  localparam int max_cycles = 2 * test_cycles;

  logic       clock;
  logic       reset;
  logic       timeout_i;
  logic       usb_sent_i;
  logic       usb_recv_i;
  logic       tok_recv_i;
  logic [2:0] usb_error_i;
  logic [3:0] usb_state_i;
  logic [7:0] blk_state_i;
  logic [1:0] line_state_i;
  logic       usb_reset_i;
  logic       crc_error_i;
  logic [3:0] usb_endpt_i;
  logic [3:0] usb_tuser_i;
  logic [3:0] ctl_state_i;
  logic [3:0] phy_state_i;
  logic       usb_sof_i;
  logic       high_speed_i;
  logic       usb_enum_i;
  logic       start_i;
  logic       select_i;
  logic [3:0] endpt_i;
  logic       m_ready_i;
  logic [level_bits-1:0] level_o;
  logic       m_valid_o;
  logic       m_last_o;
  logic [7:0] m_data_o;

  logic [8:0]  exp_bytes[$];
  logic [31:0] got_words[$];
  logic [31:0] got_word;
  logic [31:0] model_q;
  logic [31:0] model_prev;
  logic [10:0] sof_acc;
  logic        sof_prev;
  logic [31:0] rng_state = 32'd75;
  logic [31:0] ready_state = 32'd75;
  logic        random_ready;
  int words_pushed = 0;
  int byte_idx = 0;
  int packets_done = 0;
  int tick_words = 0;
  int checks = 0;
  int errors = 0;
  int cycle_count = 0;

  `include "telemetry_model.svh"

  bulk_telemetry bulk_telemetry_inst (
    .clock        (clock),
    .reset        (reset),
    .timeout_i    (timeout_i),
    .usb_sent_i   (usb_sent_i),
    .usb_recv_i   (usb_recv_i),
    .tok_recv_i   (tok_recv_i),
    .usb_error_i  (usb_error_i),
    .usb_state_i  (usb_state_i),
    .blk_state_i  (blk_state_i),
    .line_state_i (line_state_i),
    .usb_reset_i  (usb_reset_i),
    .crc_error_i  (crc_error_i),
    .usb_endpt_i  (usb_endpt_i),
    .usb_tuser_i  (usb_tuser_i),
    .ctl_state_i  (ctl_state_i),
    .phy_state_i  (phy_state_i),
    .usb_sof_i    (usb_sof_i),
    .high_speed_i (high_speed_i),
    .usb_enum_i   (usb_enum_i),
    .start_i      (start_i),
    .select_i     (select_i),
    .endpt_i      (endpt_i),
    .m_ready_i    (m_ready_i),
    .level_o      (level_o),
    .m_valid_o    (m_valid_o),
    .m_last_o     (m_last_o),
    .m_data_o     (m_data_o)
  );

  always #50 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic push_word(input logic [31:0] word);
    logic last;
    last = (words_pushed % packet_words) == packet_words - 1;
    for (int b = 0; b < 4; b++) begin
      exp_bytes.push_back({last && b == 3, word[8*b +: 8]});
    end
    words_pushed++;
  endtask

  // Every change bumps the PHY state so each step yields one word
  task automatic hold_change();
    phy_state_i <= phy_state_i + 4'd1;
    repeat (3) @(posedge clock);
  endtask

  task automatic random_step();
    logic [31:0] r;
    rng_state = xorshift(rng_state);
    r = rng_state;
    usb_reset_i  <= r[0];
    crc_error_i  <= r[1];
    usb_endpt_i  <= r[5:2];
    usb_tuser_i  <= r[9:6];
    usb_state_i  <= r[13:10];
    ctl_state_i  <= r[17:14];
    usb_error_i  <= r[20:18];
    line_state_i <= r[22:21];
    blk_state_i  <= 8'h01 << r[25:23];
    hold_change();
  endtask

  task automatic send_sof(input int count);
    repeat (count) begin
      usb_sof_i <= 1'b1;
      @(posedge clock);
      usb_sof_i <= 1'b0;
      @(posedge clock);
    end
  endtask

  task automatic read_packet();
    int seen;
    seen = packets_done;
    start_i  <= 1'b1;
    select_i <= 1'b1;
    endpt_i  <= telemetry_endpoint;
    @(posedge clock);
    start_i <= 1'b0;
    while (packets_done == seen) begin
      @(posedge clock);
    end
    select_i <= 1'b0;
  endtask

  task automatic try_select(input logic [3:0] endpt, input logic sel);
    start_i  <= 1'b1;
    select_i <= sel;
    endpt_i  <= endpt;
    @(posedge clock);
    start_i  <= 1'b0;
    select_i <= 1'b0;
    repeat (20) begin
      @(posedge clock);
      check_value(m_valid_o, 0, "m_valid_o without a valid selection");
    end
  endtask

  // Expected word from the inputs the DUT samples at this edge
  always @(posedge clock) begin : reference_model
    logic [11:0] sof_sum;
    logic        sof_rise;
    logic        tick;
    if (reset) begin
      model_q    = 32'h2000_0000;
      model_prev = '0;
      sof_acc    = '0;
      sof_prev   = 1'b0;
    end else begin
      if (usb_enum_i && model_q[28:0] != model_prev[28:0]) begin
        push_word(model_q);
      end
      model_prev = model_q;
      sof_sum  = accumulate_sof(sof_acc, high_speed_i);
      sof_rise = usb_sof_i && !sof_prev;
      tick     = sof_rise && sof_sum[11];
      if (sof_rise) begin
        sof_acc = sof_sum[10:0];
      end
      sof_prev = usb_sof_i;
      model_q = pack_word(line_state_i, usb_reset_i, usb_endpt_i, usb_tuser_i, usb_state_i,
        crc_error_i, priority_err_code(timeout_i, usb_sent_i, usb_recv_i, tok_recv_i,
        usb_state_i, usb_error_i), tick, one_hot_index(blk_state_i), ctl_state_i,
        phy_state_i);
    end
  end

  always @(posedge clock) begin : compare_bytes
    logic [8:0] expected;
    if (!reset && m_valid_o && m_ready_i) begin
      if (exp_bytes.size() == 0) begin
        errors++;
        $display("Byte %h arrived at %0t ns with no expected byte left", m_data_o, $time);
      end else begin
        expected = exp_bytes.pop_front();
        check_value(m_data_o, expected[7:0], "m_data_o");
        check_value(m_last_o, expected[8], "m_last_o");
      end
      got_word[8*byte_idx +: 8] = m_data_o;
      if (byte_idx == 3) begin
        got_words.push_back(got_word);
        if (got_word[11]) begin
          tick_words++;
        end
        byte_idx = 0;
      end else begin
        byte_idx++;
      end
      if (m_last_o) begin
        packets_done <= packets_done + 1;
      end
    end
  end

  always @(posedge clock) begin
    ready_state = xorshift(ready_state);
    m_ready_i <= !random_ready || ready_state[0];
  end

  initial begin : watchdog
    while (cycle_count < max_cycles) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Run stopped by timeout after %0d clock cycles", max_cycles);
    $display("%0d checks, %0d errors", checks, errors);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    clock = 1'b0;
    reset <= 1'b1;
    random_ready <= 1'b0;
    timeout_i <= 1'b0;
    usb_sent_i <= 1'b0;
    usb_recv_i <= 1'b0;
    tok_recv_i <= 1'b0;
    usb_error_i <= '0;
    usb_state_i <= '0;
    blk_state_i <= 8'h01;
    line_state_i <= 2'b01;
    usb_reset_i <= 1'b0;
    crc_error_i <= 1'b0;
    usb_endpt_i <= '0;
    usb_tuser_i <= '0;
    ctl_state_i <= '0;
    phy_state_i <= '0;
    usb_sof_i <= 1'b0;
    high_speed_i <= 1'b0;
    usb_enum_i <= 1'b1;
    start_i <= 1'b0;
    select_i <= 1'b0;
    endpt_i <= '0;
    m_ready_i <= 1'b1;
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    repeat (10) @(posedge clock);
    check_value(m_valid_o, 0, "m_valid_o after reset");
    check_value(level_o, 0, "level_o with constant inputs");
    usb_enum_i <= 1'b0;
    repeat (4) random_step();
    usb_enum_i <= 1'b1;
    repeat (3) @(posedge clock);
    check_value(level_o, 0, "level_o while not enumerated");

    repeat (16) random_step();
    @(posedge clock);
    check_value(level_o, 16, "level_o after 16 changes");
    read_packet();
    check_value(level_o, 8, "level_o after one packet");
    read_packet();
    check_value(level_o, 0, "level_o after two packets");

    // Priority cases start from a cleared usb state so suspend cannot mask sent
    timeout_i <= 1'b1;
    usb_sent_i <= 1'b1;
    usb_state_i <= 4'h0;
    hold_change();
    timeout_i <= 1'b0;
    hold_change();
    usb_sent_i <= 1'b0;
    usb_recv_i <= 1'b1;
    hold_change();
    usb_recv_i <= 1'b0;
    tok_recv_i <= 1'b1;
    hold_change();
    tok_recv_i <= 1'b0;
    blk_state_i <= 8'h03;
    hold_change();
    blk_state_i <= 8'h40;
    hold_change();
    usb_state_i <= 4'h8;
    hold_change();
    usb_state_i <= 4'h0;
    hold_change();
    @(posedge clock);
    check_value(level_o, 8, "level_o after priority cases");
    read_packet();
    check_value(got_words[16][14:12], 7, "error code for timeout with sent");
    check_value(got_words[17][14:12], 5, "error code for sent alone");
    check_value(got_words[20][10:8], 7, "bulk index for a non one-hot state");
    check_value(got_words[21][10:8], 6, "bulk index for state bit 6");
    check_value(got_words[22][14:12], 6, "error code in suspend");

    send_sof(255);
    repeat (3) @(posedge clock);
    check_value(level_o, 0, "level_o before the full-speed tick");
    send_sof(1);
    repeat (4) @(posedge clock);
    check_value(level_o, 2, "level_o after the full-speed tick");
    high_speed_i <= 1'b1;
    send_sof(2047);
    repeat (3) @(posedge clock);
    check_value(level_o, 2, "level_o before the high-speed tick");
    send_sof(1);
    repeat (4) @(posedge clock);
    check_value(level_o, 4, "level_o after the high-speed tick");

    repeat (4) random_step();
    @(posedge clock);
    check_value(level_o, 8, "level_o before filtered selects");
    try_select(4'd3, 1'b1);
    try_select(telemetry_endpoint, 1'b0);
    random_ready <= 1'b1;
    read_packet();
    random_ready <= 1'b0;
    check_value(tick_words, 2, "delivered words with the SOF tick set");
    check_value(level_o, 0, "level_o at the end");
    check_value(exp_bytes.size(), 0, "expected bytes never delivered");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
